/* conv_feed_pkg.sv */
package conv_feed_pkg;

  // -------------------------------------------------------------------------
  // datapath widths and kernel geometry
  // -------------------------------------------------------------------------
  localparam int DATA_W      = 8;
  localparam int KERNEL_DIM  = 3;
  localparam int KERNEL_SIZE = KERNEL_DIM * KERNEL_DIM;
  localparam int KIDX_W      = 4;   // kernel index or weight rank
  localparam int POS_W       = 4;   // pixel row or column for image sides up to 16

  typedef logic signed [DATA_W-1:0] weight_t;
  typedef logic        [DATA_W-1:0] act_t;

  // bit k belongs to kernel tap k = ky*3 + kx
  typedef logic [KERNEL_SIZE-1:0] kmask_t;

  // -------------------------------------------------------------------------
  // apb register map
  // -------------------------------------------------------------------------
  localparam int PADDR_W = 12;
  localparam int PDATA_W = 32;

  localparam logic [PADDR_W-1:0] REG_CTRL   = 12'h000;
  localparam logic [PADDR_W-1:0] REG_STATUS = 12'h004;
  localparam logic [PADDR_W-1:0] REG_MASK   = 12'h008;
  localparam logic [PADDR_W-1:0] WEI_BASE   = 12'h100;  // compressed weight slots
  localparam logic [PADDR_W-1:0] ACT_BASE   = 12'h400;  // one image pixel per word

  // control and status bits
  localparam int CTRL_START_BIT = 0;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;

endpackage

/* operand_ram.sv */
module operand_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 9,
  parameter int  AW        = 4
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          we_i,
  input  logic [AW-1:0] waddr_i,
  input  payload_t      wdata_i,
  input  logic          re_i,
  input  logic [AW-1:0] raddr_i,
  output payload_t      rdata_o
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // read register holds its value while re_i is low
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      rdata_o <= '0;
    end else if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

endmodule

/* apb_load_port.sv */
module apb_load_port #(
  parameter int IMG_W  = 8,
  parameter int IMG_H  = 8,
  parameter int ACT_AW = 6
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [conv_feed_pkg::PADDR_W-1:0] paddr_i,
  input  logic [conv_feed_pkg::PDATA_W-1:0] pwdata_i,
  output logic [conv_feed_pkg::PDATA_W-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  input  logic                              busy_i,
  input  logic                              done_i,
  output conv_feed_pkg::kmask_t             mask_o,
  output logic                              start_o,
  output logic                              wei_we_o,
  output logic [conv_feed_pkg::KIDX_W-1:0]  wei_waddr_o,
  output conv_feed_pkg::weight_t            wei_wdata_o,
  output logic                              act_we_o,
  output logic [ACT_AW-1:0]                 act_waddr_o,
  output conv_feed_pkg::act_t               act_wdata_o
);
  import conv_feed_pkg::*;

  localparam int NPIX = IMG_W * IMG_H;

  logic               access;   // apb access phase
  logic               wr_acc;
  logic [PADDR_W-1:0] wei_off;
  logic [PADDR_W-1:0] act_off;
  logic               hit_ctrl;
  logic               hit_status;
  logic               hit_mask;
  logic               hit_wei;
  logic               hit_act;
  logic               hit_reg;
  logic               hit_mem;

  assign access  = psel_i & penable_i;
  assign wr_acc  = access & pwrite_i;
  assign wei_off = paddr_i - WEI_BASE;
  assign act_off = paddr_i - ACT_BASE;

  // -------------------------------------------------------------------------
  // address decode
  // -------------------------------------------------------------------------
  assign hit_ctrl   = (paddr_i == REG_CTRL);
  assign hit_status = (paddr_i == REG_STATUS);
  assign hit_mask   = (paddr_i == REG_MASK);

  // word aligned slots only
  assign hit_wei = (paddr_i >= WEI_BASE) && (wei_off < PADDR_W'(4 * KERNEL_SIZE)) &&
                   (paddr_i[1:0] == 2'b00);
  assign hit_act = (paddr_i >= ACT_BASE) && (act_off < PADDR_W'(4 * NPIX)) &&
                   (paddr_i[1:0] == 2'b00);

  assign hit_reg = hit_ctrl | hit_status | hit_mask;
  assign hit_mem = hit_wei | hit_act;

  assign pready_o = 1'b1;   // no wait states

  // memories are write only and locked while a run is active
  assign pslverr_o = access & (~(hit_reg | hit_mem) | (hit_mem & (~pwrite_i | busy_i)));

  // ram write ports driven straight from the access phase
  assign wei_we_o    = wr_acc & hit_wei & ~busy_i;
  assign wei_waddr_o = wei_off[KIDX_W+1:2];
  assign wei_wdata_o = weight_t'(pwdata_i[DATA_W-1:0]);

  assign act_we_o    = wr_acc & hit_act & ~busy_i;
  assign act_waddr_o = act_off[ACT_AW+1:2];
  assign act_wdata_o = act_t'(pwdata_i[DATA_W-1:0]);

  // -------------------------------------------------------------------------
  // mask register and start pulse
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      mask_o  <= '0;
      start_o <= 1'b0;
    end else begin
      // start while busy is dropped
      start_o <= wr_acc & hit_ctrl & pwdata_i[CTRL_START_BIT] & ~busy_i;
      // mask stays frozen for the whole run
      if (wr_acc && hit_mask && !busy_i) begin
        mask_o <= pwdata_i[KERNEL_SIZE-1:0];
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    if (hit_status) begin
      prdata_o[STAT_BUSY_BIT] = busy_i;
      prdata_o[STAT_DONE_BIT] = done_i;
    end else if (hit_mask) begin
      prdata_o[KERNEL_SIZE-1:0] = mask_o;
    end
  end

endmodule

/* sparse_index_scan.sv */
module sparse_index_scan (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             load_i,
  input  conv_feed_pkg::kmask_t            mask_i,
  input  logic                             step_i,
  output logic [conv_feed_pkg::KIDX_W-1:0] idx_o,
  output logic [conv_feed_pkg::KIDX_W-1:0] rank_o,
  output logic                             empty_o,
  output logic                             final_o
);
  import conv_feed_pkg::*;

  kmask_t work;     // flags not yet visited for this pixel
  kmask_t lowest;   // one-hot
  kmask_t rest;

  // two's complement isolation of the lowest set flag
  assign lowest = work & (~work + 1'b1);
  assign rest   = work & ~lowest;

  assign empty_o = (work == '0);
  assign final_o = ~empty_o & (rest == '0);   // exactly one flag left

  // one-hot to kernel index
  always_comb begin
    idx_o = '0;
    for (int k = 0; k < KERNEL_SIZE; k++) begin
      if (lowest[k]) begin
        idx_o = KIDX_W'(k);
      end
    end
  end

  // -------------------------------------------------------------------------
  // working copy and rank counter
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      work   <= '0;
      rank_o <= '0;
    end else if (load_i) begin
      work   <= mask_i;   // restart at the first tap
      rank_o <= '0;
    end else if (step_i && !empty_o) begin
      work   <= rest;
      rank_o <= rank_o + 1'b1;   // next compressed weight slot
    end
  end

endmodule

/* window_addr_gen.sv */
module window_addr_gen #(
  parameter int IMG_W  = 8,
  parameter int ACT_AW = 6
) (
  input  logic [conv_feed_pkg::POS_W-1:0]  row_i,
  input  logic [conv_feed_pkg::POS_W-1:0]  col_i,
  input  logic [conv_feed_pkg::KIDX_W-1:0] kidx_i,
  output logic [ACT_AW-1:0]                addr_o
);
  import conv_feed_pkg::*;

  logic [3:0]       kyx;   // {ky, kx}
  logic [POS_W-1:0] win_row;
  logic [POS_W-1:0] win_col;

  // kernel index to row and column offset
  always_comb begin
    case (kidx_i)
      4'd0:    kyx = {2'd0, 2'd0};
      4'd1:    kyx = {2'd0, 2'd1};
      4'd2:    kyx = {2'd0, 2'd2};
      4'd3:    kyx = {2'd1, 2'd0};
      4'd4:    kyx = {2'd1, 2'd1};
      4'd5:    kyx = {2'd1, 2'd2};
      4'd6:    kyx = {2'd2, 2'd0};
      4'd7:    kyx = {2'd2, 2'd1};
      4'd8:    kyx = {2'd2, 2'd2};
      default: kyx = {2'd0, 2'd0};
    endcase
  end

  assign win_row = row_i + POS_W'(kyx[3:2]);
  assign win_col = col_i + POS_W'(kyx[1:0]);

  // row-major image layout
  assign addr_o = ACT_AW'(win_row * IMG_W + win_col);

endmodule

/* feed_ctrl.sv */
module feed_ctrl #(
  parameter int IMG_W = 8,
  parameter int IMG_H = 8
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start_i,
  input  logic                             mask_zero_i,
  input  logic                             out_ready_i,
  input  logic [conv_feed_pkg::KIDX_W-1:0] scan_idx_i,
  input  logic                             scan_empty_i,
  input  logic                             scan_final_i,
  output logic                             scan_load_o,
  output logic                             scan_step_o,
  output logic [conv_feed_pkg::POS_W-1:0]  row_o,
  output logic [conv_feed_pkg::POS_W-1:0]  col_o,
  output logic                             rd_en_o,
  output logic [conv_feed_pkg::KIDX_W-1:0] kidx_o,
  output logic                             last_o,
  output logic                             valid_o,
  output logic                             busy_o,
  output logic                             done_o
);
  import conv_feed_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } state_t;

  // last valid output pixel position
  localparam logic [POS_W-1:0] COL_LAST = POS_W'(IMG_W - KERNEL_DIM);
  localparam logic [POS_W-1:0] ROW_LAST = POS_W'(IMG_H - KERNEL_DIM);

  state_t state;
  logic   launch;    // accepted start
  logic   stall;
  logic   issue;
  logic   pix_end;   // final tap of the current pixel goes out
  logic   run_end;

  assign launch  = (state == IDLE) & start_i;
  assign stall   = valid_o & ~out_ready_i;
  assign issue   = (state == ISSUE) & ~stall & ~scan_empty_i;
  assign pix_end = issue & scan_final_i;
  assign run_end = pix_end & (col_o == COL_LAST) & (row_o == ROW_LAST);

  assign rd_en_o     = issue;
  assign scan_step_o = issue & ~scan_final_i;
  assign scan_load_o = (launch & ~mask_zero_i) | pix_end;   // reload for each pixel
  assign busy_o      = (state != IDLE);

  // -------------------------------------------------------------------------
  // control FSM
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state  <= IDLE;
      done_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            done_o <= 1'b0;
            // empty kernel has nothing to issue
            state  <= mask_zero_i ? DRAIN : ISSUE;
          end
        end
        ISSUE: begin
          if (run_end) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          // output stage empty or its last triple taken this edge
          if (!stall) begin
            state  <= IDLE;
            done_o <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // row-major pixel counters
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      row_o <= '0;
      col_o <= '0;
    end else if (launch) begin
      row_o <= '0;
      col_o <= '0;
    end else if (pix_end) begin
      if (col_o == COL_LAST) begin
        col_o <= '0;
        if (row_o != ROW_LAST) begin
          row_o <= row_o + 1'b1;
        end
      end else begin
        col_o <= col_o + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // output stage lined up with the registered ram read
  // -------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      valid_o <= 1'b0;
      kidx_o  <= '0;
      last_o  <= 1'b0;
    end else if (!stall) begin
      valid_o <= issue;
      kidx_o  <= scan_idx_i;
      last_o  <= issue & scan_final_i;
    end
  end

endmodule

/* conv_feed_top.sv */
module conv_feed_top #(
  parameter int IMG_W = 8,
  parameter int IMG_H = 8
) (
  input  logic                              clk,
  input  logic                              reset,
  // apb
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [conv_feed_pkg::PADDR_W-1:0] paddr_i,
  input  logic [conv_feed_pkg::PDATA_W-1:0] pwdata_i,
  output logic [conv_feed_pkg::PDATA_W-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // operand stream
  output logic                              out_valid_o,
  output conv_feed_pkg::weight_t            out_weight_o,
  output conv_feed_pkg::act_t               out_act_o,
  output logic [conv_feed_pkg::KIDX_W-1:0]  out_kidx_o,
  output logic                              out_last_o,
  input  logic                              out_ready_i,
  output logic                              done_o
);
  import conv_feed_pkg::*;

  localparam int ACT_AW = $clog2(IMG_W * IMG_H);

  kmask_t              mask;
  logic                mask_zero;
  logic                start;
  logic                busy;
  logic                wei_we;
  logic [KIDX_W-1:0]   wei_waddr;
  weight_t             wei_wdata;
  logic                act_we;
  logic [ACT_AW-1:0]   act_waddr;
  act_t                act_wdata;
  logic                scan_load;
  logic                scan_step;
  logic [KIDX_W-1:0]   scan_idx;
  logic [KIDX_W-1:0]   scan_rank;
  logic                scan_empty;
  logic                scan_final;
  logic [POS_W-1:0]    pix_row;
  logic [POS_W-1:0]    pix_col;
  logic [ACT_AW-1:0]   act_raddr;
  logic                rd_en;

  assign mask_zero = (mask == '0);

  apb_load_port #(
    .IMG_W  (IMG_W),
    .IMG_H  (IMG_H),
    .ACT_AW (ACT_AW)
  ) u_apb_load_port (
    .clk         (clk),
    .reset       (reset),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .busy_i      (busy),
    .done_i      (done_o),
    .mask_o      (mask),
    .start_o     (start),
    .wei_we_o    (wei_we),
    .wei_waddr_o (wei_waddr),
    .wei_wdata_o (wei_wdata),
    .act_we_o    (act_we),
    .act_waddr_o (act_waddr),
    .act_wdata_o (act_wdata)
  );

  feed_ctrl #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) u_feed_ctrl (
    .clk          (clk),
    .reset        (reset),
    .start_i      (start),
    .mask_zero_i  (mask_zero),
    .out_ready_i  (out_ready_i),
    .scan_idx_i   (scan_idx),
    .scan_empty_i (scan_empty),
    .scan_final_i (scan_final),
    .scan_load_o  (scan_load),
    .scan_step_o  (scan_step),
    .row_o        (pix_row),
    .col_o        (pix_col),
    .rd_en_o      (rd_en),
    .kidx_o       (out_kidx_o),
    .last_o       (out_last_o),
    .valid_o      (out_valid_o),
    .busy_o       (busy),
    .done_o       (done_o)
  );

  sparse_index_scan u_sparse_index_scan (
    .clk     (clk),
    .reset   (reset),
    .load_i  (scan_load),
    .mask_i  (mask),
    .step_i  (scan_step),
    .idx_o   (scan_idx),
    .rank_o  (scan_rank),
    .empty_o (scan_empty),
    .final_o (scan_final)
  );

  window_addr_gen #(
    .IMG_W  (IMG_W),
    .ACT_AW (ACT_AW)
  ) u_window_addr_gen (
    .row_i  (pix_row),
    .col_i  (pix_col),
    .kidx_i (scan_idx),
    .addr_o (act_raddr)
  );

  // weight slots addressed by rank
  operand_ram #(
    .payload_t (weight_t),
    .DEPTH     (KERNEL_SIZE),
    .AW        (KIDX_W)
  ) u_wei_ram (
    .clk     (clk),
    .reset   (reset),
    .we_i    (wei_we),
    .waddr_i (wei_waddr),
    .wdata_i (wei_wdata),
    .re_i    (rd_en),
    .raddr_i (scan_rank),
    .rdata_o (out_weight_o)
  );

  operand_ram #(
    .payload_t (act_t),
    .DEPTH     (IMG_W * IMG_H),
    .AW        (ACT_AW)
  ) u_act_ram (
    .clk     (clk),
    .reset   (reset),
    .we_i    (act_we),
    .waddr_i (act_waddr),
    .wdata_i (act_wdata),
    .re_i    (rd_en),
    .raddr_i (act_raddr),
    .rdata_o (out_act_o)
  );

endmodule

/* tb_conv_feed.sv */
module tb_conv_feed;
  timeunit 1ns;
  timeprecision 1ps;
  import conv_feed_pkg::*;

  localparam int IMG_W    = 6;
  localparam int IMG_H    = 5;
  localparam int NPIX     = IMG_W * IMG_H;
  localparam int NOUT     = (IMG_W - 2) * (IMG_H - 2);   // valid output pixels
  localparam int NCASE    = 8;
  localparam int LOAD_CYC = 3 * (KERNEL_SIZE + NPIX + 10);
  localparam int LIMIT    = NCASE * (4 * (NOUT * KERNEL_SIZE + 20) + LOAD_CYC) + 20;

  typedef struct packed {
    kmask_t      mask;
    logic [71:0] wei;    // slot n in bits 8n+7:8n
    logic [1:0]  pat;    // image fill pattern
    logic        rnd;    // random out_ready_i
    logic        keep;   // reuse memories of the row before
    logic        errs;   // bus errors while busy
  } case_t;

  logic                 clk;
  logic                 reset;
  logic                 psel_i;
  logic                 penable_i;
  logic                 pwrite_i;
  logic [PADDR_W-1:0]   paddr_i;
  logic [PDATA_W-1:0]   pwdata_i;
  logic [PDATA_W-1:0]   prdata_o;
  logic                 pready_o;
  logic                 pslverr_o;
  logic                 out_valid_o;
  weight_t              out_weight_o;
  act_t                 out_act_o;
  logic [KIDX_W-1:0]    out_kidx_o;
  logic                 out_last_o;
  logic                 out_ready_i;
  logic                 done_o;

  logic [31:0]          lfsr = 32'h8d76_4944;
  weight_t              wei_mem [KERNEL_SIZE];   // model copy of the weight slots
  act_t                 img_mem [NPIX];
  weight_t              exp_w [$];
  act_t                 exp_a [$];
  logic [KIDX_W-1:0]    exp_k [$];
  logic                 exp_l [$];

  // mask, weights, pattern, rnd, keep, errs
  case_t cases [NCASE] = '{
    '{9'h1ff, 72'h81_7f_40_c0_10_f0_05_fb_01, 2'd0, 1'b0, 1'b0, 1'b0},
    '{9'h001, 72'h00_00_00_00_00_00_00_00_9c, 2'd1, 1'b0, 1'b0, 1'b0},
    '{9'h155, 72'h00_00_00_00_33_cc_55_aa_12, 2'd1, 1'b1, 1'b0, 1'b0},
    '{9'h0aa, 72'h11_22_33_44_e5_d6_c7_b8_a9, 2'd2, 1'b1, 1'b0, 1'b1},
    '{9'h1ff, 72'h00_00_00_00_00_00_00_00_00, 2'd0, 1'b0, 1'b1, 1'b0},
    '{9'h100, 72'h00_00_00_00_00_00_00_00_6d, 2'd0, 1'b1, 1'b0, 1'b0},
    '{9'h000, 72'h00_00_00_00_00_00_00_00_00, 2'd0, 1'b0, 1'b0, 1'b0},
    '{9'h1ff, 72'h7e_d3_2c_90_01_ff_80_7f_44, 2'd1, 1'b1, 1'b0, 1'b0}
  };

  conv_feed_top #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) conv_feed_top_i (
    .clk          (clk),
    .reset        (reset),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .out_valid_o  (out_valid_o),
    .out_weight_o (out_weight_o),
    .out_act_o    (out_act_o),
    .out_kidx_o   (out_kidx_o),
    .out_last_o   (out_last_o),
    .out_ready_i  (out_ready_i),
    .done_o       (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // -------------------------------------------------------------------------
  // helpers
  // -------------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    assert (exp_v === act_v) else begin
      $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic act_t img_value(input logic [1:0] pat, input int p);
    act_t b;
    b = '0;
    case (pat)
      2'd0:    b = act_t'(p * 37 + 11);
      2'd1: begin
        for (int i = 0; i < 8; i++) begin
          b = {b[6:0], next_bit()};
        end
      end
      default: b = act_t'(8'h5a ^ (p * 7));
    endcase
    return b;
  endfunction

  // one apb transfer with the response sampled mid access phase
  task automatic apb_xfer(input logic wr, input logic [PADDR_W-1:0] addr,
                          input logic [PDATA_W-1:0] data, input logic exp_err,
                          output logic [PDATA_W-1:0] rdata);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk);
    penable_i <= 1'b1;
    @(negedge clk);
    check_val("pready_o", 32'h1, 32'(pready_o));
    check_val("pslverr_o", 32'(exp_err), 32'(pslverr_o));
    rdata = prdata_o;
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic load_memories(input int i);
    logic [PDATA_W-1:0] rd;
    for (int n = 0; n < KERNEL_SIZE; n++) begin
      wei_mem[n] = weight_t'(cases[i].wei[8*n +: 8]);
      apb_xfer(1'b1, WEI_BASE + PADDR_W'(4 * n), {24'h0, wei_mem[n]}, 1'b0, rd);
    end
    for (int p = 0; p < NPIX; p++) begin
      img_mem[p] = img_value(cases[i].pat, p);
      apb_xfer(1'b1, ACT_BASE + PADDR_W'(4 * p), {24'h0, img_mem[p]}, 1'b0, rd);
    end
  endtask

  // reference model over row-major pixels and ascending taps
  task automatic build_expected(input kmask_t mask);
    int top;
    int rank;
    top = -1;
    exp_w.delete();
    exp_a.delete();
    exp_k.delete();
    exp_l.delete();
    for (int k = 0; k < KERNEL_SIZE; k++) begin
      if (mask[k]) top = k;
    end
    for (int r = 0; r <= IMG_H - KERNEL_DIM; r++) begin
      for (int c = 0; c <= IMG_W - KERNEL_DIM; c++) begin
        rank = 0;
        for (int k = 0; k < KERNEL_SIZE; k++) begin
          if (mask[k]) begin
            exp_w.push_back(wei_mem[rank]);   // n-th set bit takes slot n
            exp_a.push_back(img_mem[(r + k / 3) * IMG_W + c + k % 3]);
            exp_k.push_back(KIDX_W'(k));
            exp_l.push_back(k == top);
            rank++;
          end
        end
      end
    end
  endtask

  // -------------------------------------------------------------------------
  // stream consumer and checker
  // -------------------------------------------------------------------------
  task automatic run_stream(input logic rnd);
    int      n;
    logic    saw_low;
    logic    held;
    weight_t hold_w;
    act_t    hold_a;
    logic [KIDX_W-1:0] hold_k;
    logic    hold_l;
    n       = 0;
    saw_low = 1'b0;
    held    = 1'b0;
    forever begin
      @(negedge clk);
      if (!done_o) saw_low = 1'b1;   // start has cleared done
      if (held) begin   // outputs frozen during a stall
        check_val("out_valid_o", 32'h1, 32'(out_valid_o));
        check_val("out_weight_o", 32'(hold_w), 32'(out_weight_o));
        check_val("out_act_o", 32'(hold_a), 32'(out_act_o));
        check_val("out_kidx_o", 32'(hold_k), 32'(out_kidx_o));
        check_val("out_last_o", 32'(hold_l), 32'(out_last_o));
      end
      held = 1'b0;
      if (out_valid_o) begin
        if (n >= exp_k.size()) begin
          check_val("out_valid_o", 32'h0, 32'(out_valid_o));   // triple beyond the model
        end else if (out_ready_i) begin
          check_val("out_weight_o", 32'(exp_w[n]), 32'(out_weight_o));
          check_val("out_act_o", 32'(exp_a[n]), 32'(out_act_o));
          check_val("out_kidx_o", 32'(exp_k[n]), 32'(out_kidx_o));
          check_val("out_last_o", 32'(exp_l[n]), 32'(out_last_o));
          n++;
        end else begin
          held   = 1'b1;
          hold_w = out_weight_o;
          hold_a = out_act_o;
          hold_k = out_kidx_o;
          hold_l = out_last_o;
        end
      end
      if (saw_low && done_o) break;
      @(posedge clk);
      out_ready_i <= rnd ? next_bit() : 1'b1;
    end
    check_val("accepted triples", 32'(exp_k.size()), 32'(n));
  endtask

  task automatic run_case(input int i);
    logic [PDATA_W-1:0] rd;
    kmask_t             mask;
    mask = cases[i].mask;
    if (!cases[i].keep) load_memories(i);
    apb_xfer(1'b1, REG_MASK, 32'(mask), 1'b0, rd);
    apb_xfer(1'b0, REG_MASK, 32'h0, 1'b0, rd);
    check_val("prdata_o", 32'(mask), rd);
    build_expected(mask);
    apb_xfer(1'b1, REG_CTRL, 32'h1, 1'b0, rd);
    fork
      run_stream(cases[i].rnd);
      begin
        if (mask != '0) begin
          apb_xfer(1'b0, REG_STATUS, 32'h0, 1'b0, rd);
          check_val("prdata_o", 32'h1, rd);   // busy with the old done cleared
          if (cases[i].errs) begin
            apb_xfer(1'b1, WEI_BASE + 12'h008, 32'h55, 1'b1, rd);
            apb_xfer(1'b1, ACT_BASE + 12'h014, 32'haa, 1'b1, rd);
            apb_xfer(1'b0, WEI_BASE, 32'h0, 1'b1, rd);
            apb_xfer(1'b1, 12'h0fc, 32'h1, 1'b1, rd);   // unmapped
            apb_xfer(1'b1, REG_CTRL, 32'h1, 1'b0, rd);  // ignored while busy
          end
        end
      end
    join
    apb_xfer(1'b0, REG_STATUS, 32'h0, 1'b0, rd);
    check_val("prdata_o", 32'h2, rd);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", LIMIT);
    $display("Some tests failed");
    $fatal(1);
  end

  initial begin
    reset       = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    out_ready_i = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < NCASE; i++) begin
      run_case(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* tb.f */
conv_feed_pkg.sv
operand_ram.sv
apb_load_port.sv
sparse_index_scan.sv
window_addr_gen.sv
feed_ctrl.sv
conv_feed_top.sv
tb_conv_feed.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_feed \
  -f tb.f -o sim_conv_feed

./obj_dir/sim_conv_feed > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
